/* hdl/cfgSettings.svh */
`ifndef CFG_SETTINGS_SVH
`define CFG_SETTINGS_SVH

// system clock and line rate
`define CFG_CLOCK_FREQUENCY 100_000_000
`define CFG_BAUD_RATE       115_200

// clock cycles per UART bit, 868 at the values above
`define CFG_BIT_CYCLES (`CFG_CLOCK_FREQUENCY / `CFG_BAUD_RATE)

// inactivity limit in clock cycles, a little under two byte times
`define CFG_TIMEOUT_CYCLES 16_776

// frame header
`define CFG_FRAME_ID    24'h00AAFF
`define CFG_CMD_WRITE_A 7'h01      // compared against command bits 6:0
`define CFG_CMD_WRITE_B 7'h02

`endif

/* hdl/cfgPkg.sv */
`default_nettype none

package cfgPkg;

    typedef logic [7:0]  byteT;
    typedef logic [31:0] wordT;
    typedef logic [3:0]  nibbleT;

    // receiver bit sequencing
    typedef enum logic [3:0] {
        rxWaitStart  = 4'd0,  // line idle, looking for a low level
        rxStartDelay = 4'd1,  // half a bit into the start bit
        rxDataBits   = 4'd2,
        rxStopBit    = 4'd3
    } rxStateT;

    // frame sequencing, header states are consecutive
    typedef enum logic [2:0] {
        frIdle     = 3'd0,
        frId0      = 3'd1,
        frId1      = 3'd2,
        frId2      = 3'd3,
        frCommand  = 3'd4,
        frEvaluate = 3'd5,  // single cycle
        frPayload  = 3'd6
    } frameStateT;

endpackage

`default_nettype wire

/* hdl/uartRx.sv */
`default_nettype none

`include "cfgSettings.svh"

module uartRx
    import cfgPkg::*;
(
    input  logic CLK,
    input  logic resetn,
    input  logic rx,
    output byteT rxByte,
    output logic byteValid,
    output logic startSeen
);

    localparam int BitCycles  = `CFG_BIT_CYCLES;
    localparam int CountWidth = $clog2(BitCycles);
    localparam logic [CountWidth-1:0] HalfBit = CountWidth'(BitCycles / 2);
    localparam logic [CountWidth-1:0] FullBit = CountWidth'(BitCycles - 1);

    logic                  rxMeta;
    logic                  rxSync;
    logic [CountWidth-1:0] tickCount;
    logic                  tick;
    rxStateT               state;
    logic [2:0]            bitCount;
    byteT                  shiftReg;

    // line is idle high
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
        end
    end

    // held in reload while waiting, first tick lands mid start bit
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            tickCount <= HalfBit;
            tick      <= 1'b0;
        end else if (state == rxWaitStart) begin
            tickCount <= HalfBit;
            tick      <= 1'b0;
        end else if (tickCount == '0) begin
            tickCount <= FullBit;
            tick      <= 1'b1;
        end else begin
            tickCount <= tickCount - 1'b1;
            tick      <= 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state     <= rxWaitStart;
            bitCount  <= '0;
            byteValid <= 1'b0;
        end else begin
            byteValid <= 1'b0;
            case (state)
                rxWaitStart: begin
                    if (!rxSync) state <= rxStartDelay;
                end
                rxStartDelay: begin
                    if (tick) begin
                        bitCount <= '0;
                        // high again at mid bit means a glitch
                        state    <= rxSync ? rxWaitStart : rxDataBits;
                    end
                end
                rxDataBits: begin
                    if (tick) begin
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7) state <= rxStopBit;
                    end
                end
                rxStopBit: begin
                    if (tick) begin
                        byteValid <= rxSync;  // framing error drops the byte
                        state     <= rxWaitStart;
                    end
                end
                default: state <= rxWaitStart;
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge CLK) begin
        if (state == rxDataBits && tick) shiftReg <= {rxSync, shiftReg[7:1]};
    end

    assign rxByte    = shiftReg;  // stable until the next data bit
    assign startSeen = (state == rxWaitStart) && !rxSync;

endmodule

`default_nettype wire

/* hdl/frameParser.sv */
`default_nettype none

`include "cfgSettings.svh"

module frameParser
    import cfgPkg::*;
(
    input  logic CLK,
    input  logic resetn,
    input  byteT rxByte,
    input  logic byteValid,
    input  logic startSeen,
    output byteT command,
    output logic payloadActive,
    output logic dataByteValid,
    output logic binaryMode,
    output logic frameAccepted
);

    localparam int TimeoutWidth = $clog2(`CFG_TIMEOUT_CYCLES + 1);
    localparam logic [TimeoutWidth-1:0] TimeoutLoad = TimeoutWidth'(`CFG_TIMEOUT_CYCLES);

    frameStateT              state;
    logic [23:0]             idReg;
    byteT                    commandReg;
    logic [TimeoutWidth-1:0] timeoutCount;
    logic                    timedOut;
    logic                    idMatch;
    logic                    commandOk;

    assign idMatch   = (idReg == `CFG_FRAME_ID);
    assign commandOk = (commandReg[6:0] == `CFG_CMD_WRITE_A) ||
                       (commandReg[6:0] == `CFG_CMD_WRITE_B);
    assign timedOut  = (timeoutCount == '0) && (state != frIdle);

    // inactivity timer, restarted by every received byte
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            timeoutCount <= TimeoutLoad;
        end else if (state == frIdle || byteValid) begin
            timeoutCount <= TimeoutLoad;
        end else if (timeoutCount != '0) begin
            timeoutCount <= timeoutCount - 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state      <= frIdle;
            commandReg <= '0;
        end else begin
            case (state)
                frIdle: begin
                    if (startSeen) state <= frId0;
                end
                frId0, frId1, frId2, frCommand: begin
                    if (timedOut) begin
                        state <= frIdle;  // header abandoned
                    end else if (byteValid) begin
                        state <= frameStateT'(state + 3'd1);
                        if (state == frCommand) commandReg <= rxByte;
                    end
                end
                frEvaluate: begin
                    state <= (idMatch && commandOk) ? frPayload : frIdle;
                end
                frPayload: begin
                    if (timedOut) state <= frIdle;  // end of payload stream
                end
                default: state <= frIdle;
            endcase
        end
    end

    // identifier bytes, most significant first
    always_ff @(posedge CLK) begin
        if (byteValid) begin
            case (state)
                frId0:   idReg[23:16] <= rxByte;
                frId1:   idReg[15:8]  <= rxByte;
                frId2:   idReg[7:0]   <= rxByte;
                default: idReg        <= idReg;
            endcase
        end
    end

    assign command       = commandReg;
    assign payloadActive = (state == frPayload);
    assign dataByteValid = byteValid && payloadActive;
    assign binaryMode    = !commandReg[7];  // bit 7 set selects ASCII hex
    assign frameAccepted = (state == frEvaluate) && idMatch && commandOk;

endmodule

`default_nettype wire

/* hdl/hexDecoder.sv */
`default_nettype none

module hexDecoder
    import cfgPkg::*;
(
    input  logic CLK,
    input  logic resetn,
    input  byteT rxByte,
    input  logic dataByteValid,
    input  logic payloadActive,
    output byteT hexByte,
    output logic hexValid
);

    logic   digitOk;
    nibbleT digitValue;
    logic   highPending;  // first character of a pair seen
    nibbleT highNibble;

    // 0-9, A-F and a-f
    always_comb begin
        digitOk    = 1'b0;
        digitValue = rxByte[3:0];
        if (rxByte >= 8'h30 && rxByte <= 8'h39) begin
            digitOk = 1'b1;
        end else if ((rxByte >= 8'h41 && rxByte <= 8'h46) ||
                     (rxByte >= 8'h61 && rxByte <= 8'h66)) begin
            digitOk    = 1'b1;
            digitValue = rxByte[3:0] + 4'd9;  // 'A' is 0x41
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            highPending <= 1'b0;
            hexValid    <= 1'b0;
        end else begin
            hexValid <= 1'b0;
            if (!payloadActive) begin
                highPending <= 1'b0;
            end else if (dataByteValid) begin
                if (!digitOk) begin
                    highPending <= 1'b0;  // stray character, drop half byte
                end else if (!highPending) begin
                    highPending <= 1'b1;
                end else begin
                    highPending <= 1'b0;
                    hexValid    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (dataByteValid && digitOk) begin
            if (!highPending) highNibble <= digitValue;
            else hexByte <= {highNibble, digitValue};
        end
    end

endmodule

`default_nettype wire

/* hdl/wordAssembler.sv */
`default_nettype none

module wordAssembler
    import cfgPkg::*;
(
    input  logic CLK,
    input  logic resetn,
    input  byteT rxByte,
    input  logic dataByteValid,
    input  byteT hexByte,
    input  logic hexValid,
    input  logic binaryMode,
    input  logic frameAccepted,
    output wordT writeData,
    output logic writeStrobe
);

    logic       byteStrobe;
    byteT       byteIn;
    logic [1:0] bytePos;  // 0 is the top byte

    // raw bytes in binary mode, decoded pairs otherwise
    assign byteStrobe = binaryMode ? dataByteValid : hexValid;
    assign byteIn     = binaryMode ? rxByte : hexByte;

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            bytePos     <= '0;
            writeData   <= '0;
            writeStrobe <= 1'b0;
        end else begin
            writeStrobe <= 1'b0;
            if (frameAccepted) begin
                // new frame, forget any partial word
                bytePos   <= '0;
                writeData <= '0;
            end else if (byteStrobe) begin
                // ~bytePos is 3 - bytePos, so position 0 lands in bits 31:24
                writeData[{~bytePos, 3'b000} +: 8] <= byteIn;
                bytePos     <= bytePos + 1'b1;
                writeStrobe <= (bytePos == 2'd3);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/configUart.sv */
`default_nettype none

module configUart
    import cfgPkg::*;
(
    input  logic CLK,
    input  logic resetn,
    input  logic rx,
    output wordT writeData,
    output logic writeStrobe,
    output logic comActive,
    output byteT command
);

    byteT rxByte;
    logic byteValid;
    logic startSeen;
    logic dataByteValid;
    logic binaryMode;
    logic frameAccepted;
    byteT hexByte;
    logic hexValid;

    uartRx i_uartRx (
        .CLK      (CLK),
        .resetn   (resetn),
        .rx       (rx),
        .rxByte   (rxByte),
        .byteValid(byteValid),
        .startSeen(startSeen)
    );

    // comActive doubles as the payload phase level
    frameParser i_frameParser (
        .CLK          (CLK),
        .resetn       (resetn),
        .rxByte       (rxByte),
        .byteValid    (byteValid),
        .startSeen    (startSeen),
        .command      (command),
        .payloadActive(comActive),
        .dataByteValid(dataByteValid),
        .binaryMode   (binaryMode),
        .frameAccepted(frameAccepted)
    );

    hexDecoder i_hexDecoder (
        .CLK          (CLK),
        .resetn       (resetn),
        .rxByte       (rxByte),
        .dataByteValid(dataByteValid),
        .payloadActive(comActive),
        .hexByte      (hexByte),
        .hexValid     (hexValid)
    );

    wordAssembler i_wordAssembler (
        .CLK          (CLK),
        .resetn       (resetn),
        .rxByte       (rxByte),
        .dataByteValid(dataByteValid),
        .hexByte      (hexByte),
        .hexValid     (hexValid),
        .binaryMode   (binaryMode),
        .frameAccepted(frameAccepted),
        .writeData    (writeData),
        .writeStrobe  (writeStrobe)
    );

endmodule

`default_nettype wire

/* verification/configUartTb.sv */
`default_nettype none

`include "cfgSettings.svh"

module configUartTb
    import cfgPkg::*;
();

    localparam int BitCycles     = `CFG_BIT_CYCLES;
    localparam int TimeoutCycles = `CFG_TIMEOUT_CYCLES;

    logic CLK;
    logic resetn;
    logic rx;
    wordT writeData;
    logic writeStrobe;
    logic comActive;
    byteT command;

    int unsigned errors;
    int unsigned checks;
    logic [31:0] randState;
    wordT        gotWords[$];     // words seen on writeData
    wordT        expectWords[$];
    logic        comActiveSeen;

    always #20 CLK = ~CLK;

    configUart i_configUart (
        .CLK        (CLK),
        .resetn     (resetn),
        .rx         (rx),
        .writeData  (writeData),
        .writeStrobe(writeStrobe),
        .comActive  (comActive),
        .command    (command)
    );

    // sampled on the edge, so these are the values of the cycle before
    always @(posedge CLK) begin
        if (writeStrobe) gotWords.push_back(writeData);
        if (comActive) comActiveSeen = 1'b1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic wordT randomWord();
        randState = xorshift(randState);
        return randState;
    endfunction

    task automatic nextCycle();
        @(posedge CLK);
        #2;  // drive point just after the edge
    endtask

    task automatic driveBit(input logic level);
        rx = level;
        repeat (BitCycles) @(posedge CLK);
        #2;
    endtask

    // start, data LSB first, stop
    task automatic sendByte(input byteT value);
        driveBit(1'b0);
        for (int i = 0; i < 8; i++) driveBit(value[i]);
        driveBit(1'b1);
    endtask

    task automatic sendHeader(input logic [23:0] id, input byteT cmd);
        sendByte(id[23:16]);
        sendByte(id[15:8]);
        sendByte(id[7:0]);
        sendByte(cmd);
    endtask

    task automatic sendWord(input wordT value);
        for (int i = 3; i >= 0; i--) sendByte(value[i*8 +: 8]);  // top byte first
    endtask

    task automatic sendText(input string text);
        for (int i = 0; i < text.len(); i++) sendByte(byteT'(text[i]));
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkTrue(input string testName, input logic condition,
                             input string problem);
        checks++;
        assert (condition) else begin
            errors++;
            $display("%s: %s", testName, problem);
        end
    endtask

    task automatic waitActive(input logic level, input int limit, output logic reached);
        int count;
        count = 0;
        while (comActive !== level && count < limit) begin
            nextCycle();
            count++;
        end
        reached = (comActive === level);
    endtask

    task automatic waitWords(input int number, input int limit, output logic reached);
        int count;
        count = 0;
        while (gotWords.size() < number && count < limit) begin
            nextCycle();
            count++;
        end
        reached = (gotWords.size() >= number);
    endtask

    task automatic startTest();
        gotWords.delete();
        expectWords.delete();
        comActiveSeen = 1'b0;
    endtask

    // payload phase must end by inactivity
    task automatic finishFrame(input string testName);
        logic reached;
        waitActive(1'b0, TimeoutCycles + 2 * BitCycles, reached);
        checkTrue(testName, reached, "comActive stayed high past the inactivity timeout");
    endtask

    task automatic checkWords(input string testName);
        checkValue({testName, " word count"}, 32'(expectWords.size()), 32'(gotWords.size()));
        for (int i = 0; i < expectWords.size() && i < gotWords.size(); i++) begin
            checkValue(testName, expectWords[i], gotWords[i]);
        end
    endtask

    task automatic binaryWriteTest();
        logic reached;
        startTest();
        expectWords.push_back(randomWord());
        expectWords.push_back(randomWord());
        sendHeader(`CFG_FRAME_ID, 8'h01);
        waitActive(1'b1, 2 * BitCycles, reached);
        checkTrue("binary write", reached, "comActive did not rise after the command");
        checkValue("binary write command", 32'h01, 32'(command));
        sendWord(expectWords[0]);
        sendWord(expectWords[1]);
        waitWords(2, 2 * BitCycles, reached);
        checkTrue("binary write", reached, "fewer than two writeStrobe pulses arrived");
        finishFrame("binary write");
        checkWords("binary write");
    endtask

    // expected words are queued by the caller after startTest
    task automatic hexFrameTest(input string testName, input string text);
        logic reached;
        sendHeader(`CFG_FRAME_ID, 8'h82);
        sendText(text);
        waitWords(expectWords.size(), 2 * BitCycles, reached);
        checkTrue(testName, reached, "writeStrobe pulses missing after the hex text");
        finishFrame(testName);
        checkWords(testName);
    endtask

    task automatic rejectTest(input string testName, input logic [23:0] id, input byteT cmd);
        startTest();
        sendHeader(id, cmd);
        sendWord(32'h11223344);  // would be one word if accepted
        repeat (TimeoutCycles + BitCycles) nextCycle();
        checkWords(testName);
        checkTrue(testName, !comActiveSeen, "comActive rose for a rejected frame");
    endtask

    task automatic timeoutTest();
        logic reached;
        startTest();
        sendHeader(`CFG_FRAME_ID, 8'h01);
        sendByte(8'hab);
        sendByte(8'hcd);
        finishFrame("timeout");
        expectWords.push_back(randomWord());
        sendHeader(`CFG_FRAME_ID, 8'h01);
        sendWord(expectWords[0]);
        waitWords(1, 2 * BitCycles, reached);
        checkTrue("timeout", reached, "no writeStrobe after the frame that followed the timeout");
        finishFrame("timeout");
        checkWords("timeout");
    endtask

    initial begin
        CLK           = 1'b0;
        resetn        = 1'b0;
        rx            = 1'b1;  // line idle
        errors        = 0;
        checks        = 0;
        randState     = 32'h2c8a811e;
        comActiveSeen = 1'b0;
        repeat (5) @(posedge CLK);
        #2;
        resetn = 1'b1;
        checkValue("reset writeData", 32'h0, writeData);
        checkValue("reset command", 32'h0, 32'(command));
        checkTrue("reset", !writeStrobe && !comActive, "strobe or comActive high after reset");

        binaryWriteTest();
        startTest();
        expectWords.push_back(32'hDEADBEEF);
        expectWords.push_back(32'h12345678);
        hexFrameTest("hex write", "DeadBEEF12345678");
        rejectTest("wrong identifier", 24'h00ABFF, 8'h01);
        rejectTest("wrong command", `CFG_FRAME_ID, 8'h03);
        timeoutTest();
        startTest();
        expectWords.push_back(32'h23456789);
        hexFrameTest("non-hex character", "1G23456789");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* configUart.f */
+incdir+hdl
hdl/cfgPkg.sv
hdl/uartRx.sv
hdl/frameParser.sv
hdl/hexDecoder.sv
hdl/wordAssembler.sv
hdl/configUart.sv
verification/configUartTb.sv

/* Makefile */
SOURCES := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv) configUart.f

.PHONY: all run clean

all: run

obj_dir/configUartTb: $(SOURCES)
	verilator --binary -j 0 -Wno-fatal --top-module configUartTb -f configUart.f -o configUartTb

run: obj_dir/configUartTb
	obj_dir/configUartTb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
